//--- Makefile
# Verilator build and run of the pipelined core testbench

VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= sim failed

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG) for failure"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS FAIL_MSG"

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then echo "Test FAILED"; exit 1; fi; \
	if [ $$status -ne 0 ]; then echo "Simulator exited with $$status"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- cpu_pkg.sv
/*
 * Shared definitions for the five-stage RV32I-subset core.
 * Widths, major opcodes, ALU and branch codes, and the instruction word views.
 * Every stage and the testbench take these by wildcard import.
 */
package cpu_pkg;

  localparam int XLEN    = 32;  // Data and address width
  localparam int REG_AW  = 5;   // Register index width
  localparam int PC_STEP = 4;   // Bytes per instruction

  // Major opcodes of the supported subset
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // ecall halts only with a7 (x17) == 10
  localparam logic [REG_AW-1:0] HALT_REG  = 5'd17;
  localparam logic [XLEN-1:0]   HALT_CODE = 32'd10;

  localparam logic [XLEN-1:0] NOP_INST = 32'h0000_0013;  // addi x0,x0,0

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE
  } br_kind_e;

  // One instruction word, five encodings
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r_fmt;
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i_fmt;
    struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
    } s_fmt;
    struct packed {
      logic       imm12;
      logic [5:0] imm10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      logic [6:0] opcode;
    } b_fmt;
    struct packed {
      logic       imm20;
      logic [9:0] imm10_1;
      logic       imm11;
      logic [7:0] imm19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j_fmt;
  } inst_t;

endpackage

//--- cpu_sva.sv
/*
 * Concurrent checks on the core's top-level outputs, bound into cpu_top.
 * Covers the retirement strobe, the halted flag and the fetch address out of reset.
 */
module cpu_sva import cpu_pkg::*; (
  input logic              clk,
  input logic              reset,
  input logic [XLEN-1:0]   imem_addr,
  input logic              wb_valid,
  input logic [REG_AW-1:0] wb_rd,
  input logic              is_halted
);

  // Retirements never name x0
  a_rd_nonzero: assert property (@(posedge clk) disable iff (reset)
    wb_valid |-> wb_rd != '0) else $error("wb_valid raised with rd x0");

  a_halt_sticky: assert property (@(posedge clk) disable iff (reset)
    is_halted |=> is_halted) else $error("is_halted fell without reset");

  // Nothing retires once halted
  a_quiet_halt: assert property (@(posedge clk) disable iff (reset)
    is_halted |-> !wb_valid) else $error("retirement after is_halted");

  a_reset_pc: assert property (@(posedge clk)
    reset |=> imem_addr == '0) else $error("imem_addr not zero after reset");

endmodule

bind cpu_top cpu_sva u_sva (
  .clk, .reset, .imem_addr, .wb_valid, .wb_rd, .is_halted
);

//--- cpu_tb.sv
/*
 * Testbench for the pipelined core. Serves the fetch port from a program array,
 * predicts retirements with an in-order ISA model and checks each wb_valid
 * event against that list. Directed tests run one after another from reset.
 */
module cpu_tb import cpu_pkg::*; ();

  localparam int DMEM_WORDS = 64;
  localparam int PROG_WORDS = 128;
  localparam logic [6:0] F7_BASE = 7'h00;
  localparam logic [6:0] F7_SUB  = 7'h20;

  logic              clk = 1'b0;
  logic              reset;
  logic [XLEN-1:0]   imem_addr;
  logic [XLEN-1:0]   imem_data;
  logic              wb_valid;
  logic [REG_AW-1:0] wb_rd;
  logic [XLEN-1:0]   wb_data;
  logic              is_halted;

  logic [XLEN-1:0] prog [PROG_WORDS];  // Fetch-port memory
  int              prog_len;
  int              exp_rd [$];         // Expected retirements, in order
  logic [XLEN-1:0] exp_val [$];
  logic            exp_halt;
  int              ret_idx;
  int              cycles = 0;
  int              cycle_limit = 50;   // Grows by 8 per loaded instruction

  cpu_top #(.DMEM_WORDS(DMEM_WORDS)) UUT (
    .clk, .reset, .imem_addr, .imem_data,
    .wb_valid, .wb_rd, .wb_data, .is_halted
  );

  always #2 clk = ~clk;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [XLEN-1:0] actual,
                       input logic [XLEN-1:0] expected);
    if (actual !== expected) begin
      fail_run($sformatf("[ERROR] time %0t: %s is %0h, expected %0h",
                         $time, name, actual, expected));
    end
  endtask

  // Word at imem_addr, NOP outside the program
  always @(negedge clk) begin
    if (!$isunknown(imem_addr) && imem_addr < XLEN'(PROG_WORDS * PC_STEP))
      imem_data <= prog[imem_addr[8:2]];
    else
      imem_data <= NOP_INST;
  end

  always @(negedge clk) begin
    if (!reset && wb_valid) begin
      if (ret_idx >= exp_rd.size()) begin
        fail_run($sformatf("Unexpected retirement of x%0d at time %0t", wb_rd, $time));
      end else begin
        check("wb_rd", XLEN'(wb_rd), XLEN'(exp_rd[ret_idx]));
        check("wb_data", wb_data, exp_val[ret_idx]);
        ret_idx++;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit)
      fail_run($sformatf("Timeout after %0d cycles without the tests completing", cycles));
  end

  // Instruction encoders
  function automatic logic [XLEN-1:0] rtype(input logic [6:0] f7, input logic [2:0] f3,
                                            input int rd, input int rs1, input int rs2);
    inst_t w;
    w.r_fmt = '{f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OPC_OP};
    return w;
  endfunction

  function automatic logic [XLEN-1:0] itype(input logic [6:0] opc, input logic [2:0] f3,
                                            input int rd, input int rs1, input int imm);
    inst_t w;
    w.i_fmt = '{imm[11:0], rs1[4:0], f3, rd[4:0], opc};
    return w;
  endfunction

  function automatic logic [XLEN-1:0] stype(input int rs2, input int rs1, input int imm);
    inst_t w;
    w.s_fmt = '{imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OPC_STORE};
    return w;
  endfunction

  function automatic logic [XLEN-1:0] btype(input logic [2:0] f3, input int rs1,
                                            input int rs2, input int off);
    inst_t w;
    w.b_fmt = '{off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], OPC_BRANCH};
    return w;
  endfunction

  function automatic logic [XLEN-1:0] jtype(input int rd, input int off);
    inst_t w;
    w.j_fmt = '{off[20], off[10:1], off[11], off[19:12], rd[4:0], OPC_JAL};
    return w;
  endfunction

  task automatic emit(input logic [XLEN-1:0] word);
    prog[prog_len] = word;
    prog_len++;
  endtask

  task automatic emit_halt();
    emit(itype(OPC_OP_IMM, 3'b000, 17, 0, 10));   // a7 = 10
    emit(itype(OPC_SYSTEM, 3'b000, 0, 0, 0));     // ecall
  endtask

  // RV32I arithmetic by funct3
  function automatic logic [XLEN-1:0] alu_result(input logic [2:0] f3, input logic sub,
                                                 input logic [XLEN-1:0] a,
                                                 input logic [XLEN-1:0] b);
    case (f3)
      3'b000:  return sub ? a - b : a + b;
      3'b010:  return {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      3'b100:  return a ^ b;
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input logic [XLEN-1:0] a,
                                        input logic [XLEN-1:0] b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      default: return $signed(a) >= $signed(b);
    endcase
  endfunction

  // In-order ISA model over the loaded program
  task automatic predict();
    logic [XLEN-1:0] x [32];
    logic [XLEN-1:0] mem [DMEM_WORDS];
    logic [XLEN-1:0] pc, nxt, a, b, res, ea;
    inst_t           w;
    logic            wr;
    int              steps;
    for (int i = 0; i < 32; i++) x[i] = '0;
    for (int i = 0; i < DMEM_WORDS; i++) mem[i] = '0;
    exp_rd.delete();
    exp_val.delete();
    exp_halt = 1'b0;
    pc = '0;
    steps = 0;
    while (pc < XLEN'(prog_len * PC_STEP) && !exp_halt && steps < 1000) begin
      w   = prog[pc[8:2]];
      a   = x[w.r_fmt.rs1];
      b   = x[w.r_fmt.rs2];
      nxt = pc + 4;
      wr  = 1'b0;
      res = '0;
      case (w.r_fmt.opcode)
        OPC_OP: begin
          wr  = 1'b1;
          res = alu_result(w.r_fmt.funct3, w.r_fmt.funct7[5], a, b);
        end
        OPC_OP_IMM: begin
          wr  = 1'b1;
          res = alu_result(w.i_fmt.funct3, 1'b0, a, XLEN'($signed(w.i_fmt.imm)));
        end
        OPC_LOAD: begin
          ea  = a + XLEN'($signed(w.i_fmt.imm));
          wr  = 1'b1;
          res = mem[(ea >> 2) % DMEM_WORDS];
        end
        OPC_STORE: begin
          ea = a + XLEN'($signed({w.s_fmt.imm_hi, w.s_fmt.imm_lo}));
          mem[(ea >> 2) % DMEM_WORDS] = b;
        end
        OPC_BRANCH: begin
          if (branch_taken(w.b_fmt.funct3, a, b))
            nxt = pc + XLEN'($signed({w.b_fmt.imm12, w.b_fmt.imm11, w.b_fmt.imm10_5,
                                      w.b_fmt.imm4_1, 1'b0}));
        end
        OPC_JAL: begin
          wr  = 1'b1;
          res = pc + 4;                    // Link
          nxt = pc + XLEN'($signed({w.j_fmt.imm20, w.j_fmt.imm19_12, w.j_fmt.imm11,
                                    w.j_fmt.imm10_1, 1'b0}));
        end
        OPC_SYSTEM: exp_halt = (x[17] == 32'd10);
        default: ;
      endcase
      if (wr && w.r_fmt.rd != 5'd0) begin
        x[w.r_fmt.rd] = res;
        exp_rd.push_back(int'(w.r_fmt.rd));
        exp_val.push_back(res);
      end
      pc = nxt;
      steps++;
    end
  endtask

  // Holds reset for 3 cycles; run_program releases it once the program is in
  task automatic reset_dut();
    @(negedge clk);
    reset = 1'b1;
    for (int i = 0; i < PROG_WORDS; i++) prog[i] = NOP_INST;
    prog_len = 0;
    ret_idx  = 0;
    repeat (2) @(negedge clk);
    @(posedge clk);
  endtask

  task automatic run_program();
    predict();
    cycle_limit += 8 * prog_len;
    @(negedge clk);
    reset = 1'b0;
    check("imem_addr", imem_addr, '0);         // Idle state out of reset
    check("wb_valid", XLEN'(wb_valid), '0);
    check("is_halted", XLEN'(is_halted), '0);
    while (exp_halt ? !is_halted : (ret_idx < exp_rd.size())) @(negedge clk);
    @(negedge clk);
    check("retired count", XLEN'(ret_idx), XLEN'(exp_rd.size()));
    check("is_halted", XLEN'(is_halted), XLEN'(exp_halt));
  endtask

  task automatic test_first_retire();
    reset_dut();
    emit(itype(OPC_OP_IMM, 3'b000, 5, 0, 'h123));
    run_program();
  endtask

  task automatic test_alu_forwarding();
    reset_dut();
    emit(itype(OPC_OP_IMM, 3'b000, 1, 0, 25));
    emit(itype(OPC_OP_IMM, 3'b000, 2, 0, -7));
    emit(rtype(F7_BASE, 3'b000, 3, 1, 2));     // Both operands in flight
    emit(rtype(F7_SUB, 3'b000, 4, 3, 1));
    emit(rtype(F7_BASE, 3'b010, 5, 4, 2));     // slt
    emit(rtype(F7_BASE, 3'b100, 6, 5, 3));
    emit(itype(OPC_OP_IMM, 3'b100, 7, 6, 'h5a5));
    emit(itype(OPC_OP_IMM, 3'b010, 8, 7, 100));
    emit(rtype(F7_BASE, 3'b110, 9, 8, 4));
    emit(itype(OPC_OP_IMM, 3'b111, 10, 9, 'h0f0));
    emit(rtype(F7_BASE, 3'b111, 11, 10, 3));
    emit(rtype(F7_SUB, 3'b000, 12, 0, 11));
    emit_halt();
    run_program();
  endtask

  task automatic test_load_store();
    reset_dut();
    emit(itype(OPC_OP_IMM, 3'b000, 1, 0, 'h40));  // Base address
    emit(itype(OPC_OP_IMM, 3'b000, 2, 0, -123));
    emit(stype(2, 1, 0));
    emit(itype(OPC_OP_IMM, 3'b000, 3, 0, 77));
    emit(stype(3, 1, 4));
    emit(itype(OPC_LOAD, 3'b010, 4, 1, 0));
    emit(rtype(F7_BASE, 3'b000, 5, 4, 3));        // Load-use
    emit(itype(OPC_LOAD, 3'b010, 6, 1, 4));
    emit(stype(6, 1, 8));                         // Loaded value as store data
    emit(itype(OPC_LOAD, 3'b010, 7, 1, 8));
    emit(itype(OPC_OP_IMM, 3'b000, 8, 7, 1));
    emit(itype(OPC_LOAD, 3'b010, 9, 1, -4));      // Never written
    emit_halt();
    run_program();
  endtask

  task automatic test_branches();
    reset_dut();
    emit(itype(OPC_OP_IMM, 3'b000, 1, 0, 5));
    emit(itype(OPC_OP_IMM, 3'b000, 2, 0, -3));
    emit(btype(3'b000, 1, 2, 8));                 // beq not taken
    emit(itype(OPC_OP_IMM, 3'b000, 3, 0, 1));
    emit(btype(3'b001, 1, 2, 8));                 // bne taken
    emit(itype(OPC_OP_IMM, 3'b000, 4, 0, 99));
    emit(btype(3'b100, 2, 1, 12));                // blt taken
    emit(itype(OPC_OP_IMM, 3'b000, 5, 0, 99));
    emit(itype(OPC_OP_IMM, 3'b000, 6, 0, 99));
    emit(btype(3'b101, 2, 1, 8));                 // bge not taken
    emit(itype(OPC_OP_IMM, 3'b000, 7, 0, 2));
    emit(btype(3'b100, 1, 2, 8));                 // blt not taken
    emit(btype(3'b101, 1, 2, 8));                 // bge taken
    emit(itype(OPC_OP_IMM, 3'b000, 8, 0, 99));
    emit(jtype(9, 12));
    emit(itype(OPC_OP_IMM, 3'b000, 10, 0, 99));
    emit(itype(OPC_OP_IMM, 3'b000, 11, 0, 99));
    emit(btype(3'b000, 3, 3, 8));                 // beq taken
    emit(itype(OPC_OP_IMM, 3'b000, 12, 0, 99));
    emit(rtype(F7_BASE, 3'b000, 13, 9, 3));       // Uses the link value
    emit_halt();
    run_program();
  endtask

  task automatic test_ecall_halt();
    reset_dut();
    emit(itype(OPC_OP_IMM, 3'b000, 17, 0, 3));
    emit(itype(OPC_SYSTEM, 3'b000, 0, 0, 0));     // Plain ecall, no effect
    emit(itype(OPC_OP_IMM, 3'b000, 1, 0, 11));
    emit_halt();
    emit(itype(OPC_OP_IMM, 3'b000, 2, 0, 99));    // Behind the halt
    emit(itype(OPC_OP_IMM, 3'b000, 3, 0, 98));
    run_program();
    repeat (12) @(negedge clk);
    check("is_halted", XLEN'(is_halted), 1);
  endtask

  task automatic test_random_alu();
    int k, rd, rs1, rs2;
    logic [2:0] f3;
    reset_dut();
    for (int i = 0; i < 40; i++) begin
      k   = $urandom_range(5);
      rd  = 1 + $urandom_range(6);
      rs1 = $urandom_range(7);
      rs2 = $urandom_range(7);
      case (k)
        2:       f3 = 3'b111;
        3:       f3 = 3'b110;
        4:       f3 = 3'b100;
        5:       f3 = 3'b010;
        default: f3 = 3'b000;                     // add, sub
      endcase
      if ($urandom_range(1) == 0)
        emit(rtype(k == 1 ? F7_SUB : F7_BASE, f3, rd, rs1, rs2));
      else
        emit(itype(OPC_OP_IMM, f3, rd, rs1, int'($urandom)));
    end
    emit_halt();
    run_program();
  endtask

  initial begin
    reset = 1'b1;
    imem_data = NOP_INST;
    void'($urandom(96));
    test_first_retire();
    test_alu_forwarding();
    test_load_store();
    test_branches();
    test_ecall_halt();
    test_random_alu();
    $display("sim passed");
    $finish;
  end

endmodule

//--- cpu_top.sv
/*
 * Top of the pipelined core. Holds the PC and the IF/ID register and wires
 * decode, execute and result stages together. Instruction memory is external:
 * imem_data must return the word at imem_addr in the same cycle.
 */
module cpu_top import cpu_pkg::*; #(
  parameter int DMEM_WORDS = 64
) (
  input  logic              clk,
  input  logic              reset,
  output logic [XLEN-1:0]   imem_addr,
  input  logic [XLEN-1:0]   imem_data,
  output logic              wb_valid,
  output logic [REG_AW-1:0] wb_rd,
  output logic [XLEN-1:0]   wb_data,
  output logic              is_halted
);

  logic [XLEN-1:0] pc;
  inst_t           if_inst;  // IF/ID instruction
  logic [XLEN-1:0] if_pc;    // IF/ID pc

  logic stall;
  logic redirect;
  logic halt_seen;
  logic [XLEN-1:0] redirect_pc;

  // ID/EX
  logic [XLEN-1:0]   id_ex_pc, id_ex_rs1_val, id_ex_rs2_val, id_ex_imm;
  logic [REG_AW-1:0] id_ex_rs1, id_ex_rs2, id_ex_rd;
  alu_op_e           id_ex_alu_op;
  br_kind_e          id_ex_br;
  logic id_ex_use_imm, id_ex_mem_read, id_ex_mem_write;
  logic id_ex_reg_write, id_ex_is_jal, id_ex_is_ecall;

  // EX/MEM
  logic [XLEN-1:0]   ex_mem_alu, ex_mem_store_val;
  logic [REG_AW-1:0] ex_mem_rd;
  logic ex_mem_mem_read, ex_mem_mem_write, ex_mem_reg_write;
  logic [XLEN-1:0]   mem_fwd_data;

  assign imem_addr = pc;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (halt_seen) begin
      pc <= pc;                    // Frozen after halting ecall
    end else if (redirect) begin
      pc <= redirect_pc;
    end else if (!stall) begin
      pc <= pc + XLEN'(PC_STEP);
    end
  end

  always_ff @(posedge clk) begin
    if (reset || redirect || halt_seen) begin
      if_inst <= NOP_INST;         // Squash wrong-path fetch
      if_pc   <= '0;
    end else if (!stall) begin
      if_inst <= imem_data;
      if_pc   <= pc;
    end
  end

  decode_stage u_decode (
    .clk, .reset, .if_inst, .if_pc,
    .flush (redirect),
    .wb_valid, .wb_rd, .wb_data,
    .stall,
    .id_ex_pc, .id_ex_rs1_val, .id_ex_rs2_val, .id_ex_imm,
    .id_ex_rs1, .id_ex_rs2, .id_ex_rd,
    .id_ex_alu_op, .id_ex_br,
    .id_ex_use_imm, .id_ex_mem_read, .id_ex_mem_write,
    .id_ex_reg_write, .id_ex_is_jal, .id_ex_is_ecall
  );

  execute_stage u_execute (
    .clk, .reset,
    .id_ex_pc, .id_ex_rs1_val, .id_ex_rs2_val, .id_ex_imm,
    .id_ex_rs1, .id_ex_rs2, .id_ex_rd,
    .id_ex_alu_op, .id_ex_br,
    .id_ex_use_imm, .id_ex_mem_read, .id_ex_mem_write,
    .id_ex_reg_write, .id_ex_is_jal, .id_ex_is_ecall,
    .mem_fwd_data, .wb_valid, .wb_rd, .wb_data,
    .redirect, .redirect_pc, .halt_seen,
    .ex_mem_alu, .ex_mem_store_val, .ex_mem_rd,
    .ex_mem_mem_read, .ex_mem_mem_write, .ex_mem_reg_write
  );

  result_stage #(.DMEM_WORDS(DMEM_WORDS)) u_result (
    .clk, .reset,
    .ex_mem_alu, .ex_mem_store_val, .ex_mem_rd,
    .ex_mem_mem_read, .ex_mem_mem_write, .ex_mem_reg_write,
    .ex_halt (halt_seen),
    .mem_fwd_data, .wb_valid, .wb_rd, .wb_data, .is_halted
  );

endmodule

//--- decode_stage.sv
/*
 * Decode stage. Reads the IF/ID word through its format views, builds the
 * immediate and control, detects load-use and fills the ID/EX register.
 * A stall or a flush from execute turns the ID/EX entry into a bubble.
 */
module decode_stage import cpu_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  inst_t             if_inst,
  input  logic [XLEN-1:0]   if_pc,
  input  logic              flush,
  input  logic              wb_valid,
  input  logic [REG_AW-1:0] wb_rd,
  input  logic [XLEN-1:0]   wb_data,
  output logic              stall,
  output logic [XLEN-1:0]   id_ex_pc,
  output logic [XLEN-1:0]   id_ex_rs1_val,
  output logic [XLEN-1:0]   id_ex_rs2_val,
  output logic [XLEN-1:0]   id_ex_imm,
  output logic [REG_AW-1:0] id_ex_rs1,
  output logic [REG_AW-1:0] id_ex_rs2,
  output logic [REG_AW-1:0] id_ex_rd,
  output alu_op_e           id_ex_alu_op,
  output br_kind_e          id_ex_br,
  output logic              id_ex_use_imm,
  output logic              id_ex_mem_read,
  output logic              id_ex_mem_write,
  output logic              id_ex_reg_write,
  output logic              id_ex_is_jal,
  output logic              id_ex_is_ecall
);

  logic [REG_AW-1:0] rs1_idx, rs2_idx;
  logic [XLEN-1:0]   rs1_val, rs2_val, imm;
  logic [2:0]        f3;
  logic              f3_alu_ok;
  logic              uses_rs1, uses_rs2;
  alu_op_e           alu_op;
  br_kind_e          br;
  logic use_imm, mem_read, mem_write, reg_write, is_jal, is_ecall;

  // funct3 to ALU op, shared by OP and OP_IMM
  function automatic alu_op_e f3_to_alu(input logic [2:0] code);
    case (code)
      3'b010:  return ALU_SLT;
      3'b100:  return ALU_XOR;
      3'b110:  return ALU_OR;
      3'b111:  return ALU_AND;
      default: return ALU_ADD;
    endcase
  endfunction

  assign f3 = if_inst.r_fmt.funct3;
  assign f3_alu_ok = f3 inside {3'b000, 3'b010, 3'b100, 3'b110, 3'b111};

  always_comb begin
    alu_op = ALU_ADD;
    br = BR_NONE;
    imm = '0;
    {use_imm, mem_read, mem_write, reg_write, is_jal, is_ecall} = '0;
    {uses_rs1, uses_rs2} = '0;   // Unknown opcode falls through as no-op
    case (if_inst.r_fmt.opcode)
      OPC_OP: begin
        alu_op = (f3 == 3'b000 && if_inst.r_fmt.funct7[5]) ? ALU_SUB : f3_to_alu(f3);
        reg_write = f3_alu_ok && (if_inst.r_fmt.funct7 == 7'h00 ||
                    (f3 == 3'b000 && if_inst.r_fmt.funct7 == 7'h20));
        {uses_rs1, uses_rs2} = 2'b11;
      end
      OPC_OP_IMM: begin
        alu_op = f3_to_alu(f3);
        imm = {{20{if_inst.i_fmt.imm[11]}}, if_inst.i_fmt.imm};
        {use_imm, reg_write, uses_rs1} = {2'b11, 1'b1} & {3{f3_alu_ok}};
      end
      OPC_LOAD: begin
        imm = {{20{if_inst.i_fmt.imm[11]}}, if_inst.i_fmt.imm};
        {use_imm, mem_read, reg_write, uses_rs1} = {4{f3 == 3'b010}};  // lw only
      end
      OPC_STORE: begin
        imm = {{20{if_inst.s_fmt.imm_hi[6]}}, if_inst.s_fmt.imm_hi, if_inst.s_fmt.imm_lo};
        {use_imm, mem_write, uses_rs1, uses_rs2} = {4{f3 == 3'b010}};  // sw only
      end
      OPC_BRANCH: begin
        imm = {{19{if_inst.b_fmt.imm12}}, if_inst.b_fmt.imm12, if_inst.b_fmt.imm11,
               if_inst.b_fmt.imm10_5, if_inst.b_fmt.imm4_1, 1'b0};
        case (f3)
          3'b000:  br = BR_EQ;
          3'b001:  br = BR_NE;
          3'b100:  br = BR_LT;
          3'b101:  br = BR_GE;
          default: br = BR_NONE;
        endcase
        {uses_rs1, uses_rs2} = {2{br != BR_NONE}};
      end
      OPC_JAL: begin
        imm = {{11{if_inst.j_fmt.imm20}}, if_inst.j_fmt.imm20, if_inst.j_fmt.imm19_12,
               if_inst.j_fmt.imm11, if_inst.j_fmt.imm10_1, 1'b0};
        {is_jal, reg_write} = 2'b11;
      end
      OPC_SYSTEM: begin
        is_ecall = (f3 == 3'b000) && (if_inst.i_fmt.imm == '0);
        uses_rs1 = is_ecall;           // Reads a7 for halt check
      end
      default: ;
    endcase
  end

  assign rs1_idx = (if_inst.r_fmt.opcode == OPC_SYSTEM) ? HALT_REG : if_inst.r_fmt.rs1;
  assign rs2_idx = if_inst.r_fmt.rs2;

  // Load in ID/EX feeding this instruction needs one bubble
  assign stall = id_ex_mem_read && id_ex_rd != '0 &&
                 ((uses_rs1 && rs1_idx == id_ex_rd) || (uses_rs2 && rs2_idx == id_ex_rd));

  reg_file u_regs (
    .clk, .reset,
    .rs1 (rs1_idx), .rs2 (rs2_idx),
    .rs1_val, .rs2_val,
    .we (wb_valid), .wr_rd (wb_rd), .wr_data (wb_data)
  );

  // ID/EX control, bubble on stall or flush
  always_ff @(posedge clk) begin
    if (reset || stall || flush) begin
      id_ex_alu_op <= ALU_ADD;
      id_ex_br     <= BR_NONE;
      {id_ex_use_imm, id_ex_mem_read, id_ex_mem_write} <= '0;
      {id_ex_reg_write, id_ex_is_jal, id_ex_is_ecall}  <= '0;
    end else begin
      id_ex_alu_op    <= alu_op;
      id_ex_br        <= br;
      id_ex_use_imm   <= use_imm;
      id_ex_mem_read  <= mem_read;
      id_ex_mem_write <= mem_write;
      id_ex_reg_write <= reg_write;
      id_ex_is_jal    <= is_jal;
      id_ex_is_ecall  <= is_ecall;
    end
  end

  // ID/EX payload
  always_ff @(posedge clk) begin
    id_ex_pc      <= if_pc;
    id_ex_rs1_val <= rs1_val;
    id_ex_rs2_val <= rs2_val;
    id_ex_imm     <= imm;
    id_ex_rs1     <= rs1_idx;
    id_ex_rs2     <= rs2_idx;
    id_ex_rd      <= if_inst.r_fmt.rd;
  end

endmodule

//--- execute_stage.sv
/*
 * Execute stage. Forwards operands from EX/MEM and writeback, runs the ALU,
 * resolves branches and jal, and detects a halting ecall.
 * Redirect is combinational; results go into the EX/MEM register.
 */
module execute_stage import cpu_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic [XLEN-1:0]   id_ex_pc,
  input  logic [XLEN-1:0]   id_ex_rs1_val,
  input  logic [XLEN-1:0]   id_ex_rs2_val,
  input  logic [XLEN-1:0]   id_ex_imm,
  input  logic [REG_AW-1:0] id_ex_rs1,
  input  logic [REG_AW-1:0] id_ex_rs2,
  input  logic [REG_AW-1:0] id_ex_rd,
  input  alu_op_e           id_ex_alu_op,
  input  br_kind_e          id_ex_br,
  input  logic              id_ex_use_imm,
  input  logic              id_ex_mem_read,
  input  logic              id_ex_mem_write,
  input  logic              id_ex_reg_write,
  input  logic              id_ex_is_jal,
  input  logic              id_ex_is_ecall,
  input  logic [XLEN-1:0]   mem_fwd_data,
  input  logic              wb_valid,
  input  logic [REG_AW-1:0] wb_rd,
  input  logic [XLEN-1:0]   wb_data,
  output logic              redirect,
  output logic [XLEN-1:0]   redirect_pc,
  output logic              halt_seen,
  output logic [XLEN-1:0]   ex_mem_alu,
  output logic [XLEN-1:0]   ex_mem_store_val,
  output logic [REG_AW-1:0] ex_mem_rd,
  output logic              ex_mem_mem_read,
  output logic              ex_mem_mem_write,
  output logic              ex_mem_reg_write
);

  logic [XLEN-1:0] op_a, op_b, alu_b, alu_res;
  logic            taken;
  logic            halt_now, halt_q;

  // Younger producer wins; EX/MEM before writeback
  function automatic logic [XLEN-1:0] fwd(input logic [REG_AW-1:0] idx,
                                          input logic [XLEN-1:0]   id_val);
    if (ex_mem_reg_write && ex_mem_rd != '0 && ex_mem_rd == idx) return mem_fwd_data;
    if (wb_valid && wb_rd == idx) return wb_data;
    return id_val;
  endfunction

  always_comb begin
    op_a = fwd(id_ex_rs1, id_ex_rs1_val);
    op_b = fwd(id_ex_rs2, id_ex_rs2_val);
  end

  assign alu_b = id_ex_use_imm ? id_ex_imm : op_b;

  always_comb begin
    case (id_ex_alu_op)
      ALU_SUB: alu_res = op_a - alu_b;
      ALU_AND: alu_res = op_a & alu_b;
      ALU_OR:  alu_res = op_a | alu_b;
      ALU_XOR: alu_res = op_a ^ alu_b;
      ALU_SLT: alu_res = XLEN'($signed(op_a) < $signed(alu_b));
      default: alu_res = op_a + alu_b;
    endcase
  end

  always_comb begin
    case (id_ex_br)
      BR_EQ:   taken = op_a == op_b;
      BR_NE:   taken = op_a != op_b;
      BR_LT:   taken = $signed(op_a) <  $signed(op_b);
      BR_GE:   taken = $signed(op_a) >= $signed(op_b);
      default: taken = 1'b0;
    endcase
  end

  // ecall reads a7 through rs1, forced in decode
  assign halt_now  = id_ex_is_ecall && op_a == HALT_CODE;
  assign halt_seen = halt_now || halt_q;

  always_ff @(posedge clk) begin
    if (reset) halt_q <= 1'b0;
    else       halt_q <= halt_seen;   // Sticky until reset
  end

  assign redirect    = taken || id_ex_is_jal || halt_seen;  // Halt also flushes
  assign redirect_pc = id_ex_pc + id_ex_imm;

  always_ff @(posedge clk) begin
    if (reset) begin
      {ex_mem_mem_read, ex_mem_mem_write, ex_mem_reg_write} <= '0;
    end else begin
      ex_mem_mem_read  <= id_ex_mem_read;
      ex_mem_mem_write <= id_ex_mem_write;
      ex_mem_reg_write <= id_ex_reg_write;
    end
  end

  always_ff @(posedge clk) begin
    ex_mem_alu       <= id_ex_is_jal ? id_ex_pc + XLEN'(PC_STEP) : alu_res;  // Link value
    ex_mem_store_val <= op_b;
    ex_mem_rd        <= id_ex_rd;
  end

endmodule

//--- reg_file.sv
/*
 * 32-entry general register file, x0 hardwired to zero.
 * Two combinational reads; a write in the same cycle is bypassed to the reads.
 */
module reg_file import cpu_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic [REG_AW-1:0] rs1,
  input  logic [REG_AW-1:0] rs2,
  output logic [XLEN-1:0]   rs1_val,
  output logic [XLEN-1:0]   rs2_val,
  input  logic              we,
  input  logic [REG_AW-1:0] wr_rd,
  input  logic [XLEN-1:0]   wr_data
);

  logic [XLEN-1:0] regs [32];
  logic            wr_live;

  assign wr_live = we && wr_rd != '0;  // x0 writes dropped

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) regs[i] <= '0;
    end else if (wr_live) begin
      regs[wr_rd] <= wr_data;
    end
  end

  // Write-through bypass
  assign rs1_val = (wr_live && wr_rd == rs1) ? wr_data : regs[rs1];
  assign rs2_val = (wr_live && wr_rd == rs2) ? wr_data : regs[rs2];

endmodule

//--- result_stage.sv
/*
 * Memory and writeback. Holds the word-addressed data memory, the MEM/WB
 * register and the halted flag. Loads read combinationally, stores write on
 * the clock edge; the writeback triple feeds decode and execute.
 */
module result_stage import cpu_pkg::*; #(
  parameter int DMEM_WORDS = 64
) (
  input  logic              clk,
  input  logic              reset,
  input  logic [XLEN-1:0]   ex_mem_alu,
  input  logic [XLEN-1:0]   ex_mem_store_val,
  input  logic [REG_AW-1:0] ex_mem_rd,
  input  logic              ex_mem_mem_read,
  input  logic              ex_mem_mem_write,
  input  logic              ex_mem_reg_write,
  input  logic              ex_halt,
  output logic [XLEN-1:0]   mem_fwd_data,
  output logic              wb_valid,
  output logic [REG_AW-1:0] wb_rd,
  output logic [XLEN-1:0]   wb_data,
  output logic              is_halted
);

  logic [XLEN-1:0] dmem [DMEM_WORDS];
  logic [XLEN-1:0] word_idx;
  logic            halt_mem;  // Halting ecall now in EX/MEM

  assign word_idx     = (ex_mem_alu >> 2) % DMEM_WORDS;  // Wraps on depth
  assign mem_fwd_data = ex_mem_mem_read ? dmem[word_idx] : ex_mem_alu;

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < DMEM_WORDS; i++) dmem[i] <= '0;
    end else if (ex_mem_mem_write) begin
      dmem[word_idx] <= ex_mem_store_val;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_valid  <= 1'b0;
      halt_mem  <= 1'b0;
      is_halted <= 1'b0;
    end else begin
      wb_valid  <= ex_mem_reg_write && ex_mem_rd != '0;  // No x0 retirements
      halt_mem  <= ex_halt;
      is_halted <= is_halted || halt_mem;
    end
  end

  // MEM/WB payload
  always_ff @(posedge clk) begin
    wb_rd   <= ex_mem_rd;
    wb_data <= mem_fwd_data;  // Load data or ALU value
  end

endmodule

//--- sources.f
cpu_pkg.sv
reg_file.sv
decode_stage.sv
execute_stage.sv
result_stage.sv
cpu_top.sv
cpu_sva.sv
cpu_tb.sv
